/* build.f */
+incdir+logic
logic/ccl_pkg.sv
logic/ccl_visited_map.sv
logic/ccl_neighbor_gen.sv
logic/ccl_sequencer.sv
logic/ccl_top.sv
test/ccl_mem_models.sv
test/ccl_tb.sv

/* Bender.yml */
package:
  name: ccl

sources:
  - include_dirs:
      - logic
    files:
      - logic/ccl_pkg.sv
      - logic/ccl_visited_map.sv
      - logic/ccl_neighbor_gen.sv
      - logic/ccl_sequencer.sv
      - logic/ccl_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/ccl_mem_models.sv
      - test/ccl_tb.sv

/* test/ccl_tb.sv */
`timescale 1ns/1ps

`include "ccl_config.svh"

module ccl_tb;

    localparam int DIM            = 1 << `CCL_DIM_BITS;
    localparam int LABELS         = 1 << `CCL_LABEL_BITS;
    localparam int TIMEOUT_CYCLES = 5 * 2_000_000;

    logic                              clk;
    logic                              reset;
    logic [7:0]                        rom_q;
    logic [$clog2(`CCL_ROM_DEPTH)-1:0] rom_a;
    logic [$clog2(`CCL_PIXELS)-1:0]    sram_a;
    logic [7:0]                        sram_d;
    logic                              sram_wen;
    logic                              finish;

    bit img [`CCL_PIXELS];
    int exp_label [`CCL_PIXELS];
    int errors;
    int checks;
    int wr_count;
    int cycles;
    bit done_seen;
    bit reset_prev;

    ccl_top UUT (
        .clk      (clk),
        .reset    (reset),
        .rom_q    (rom_q),
        .rom_a    (rom_a),
        .sram_a   (sram_a),
        .sram_d   (sram_d),
        .sram_wen (sram_wen),
        .finish   (finish)
    );

    ccl_mem_models mem (
        .clk      (clk),
        .rom_a    (rom_a),
        .rom_q    (rom_q),
        .sram_a   (sram_a),
        .sram_d   (sram_d),
        .sram_wen (sram_wen)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL t=%0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // --------------------------------------------------
    // Reference labeler using an 8-connected flood fill
    // --------------------------------------------------

    function automatic void label_image();
        int q[$];
        int n;
        int nr;
        int nc;
        int count;
        bit seen [`CCL_PIXELS];
        count = 0;
        for (int p = 0; p < `CCL_PIXELS; p++) begin
            exp_label[p] = 0;
            seen[p]      = 1'b0;
        end
        for (int p = 0; p < `CCL_PIXELS; p++) begin
            if (img[p] && !seen[p]) begin
                count++;
                seen[p] = 1'b1;
                q.push_back(p);
                while (q.size() > 0) begin
                    n = q.pop_front();
                    exp_label[n] = count % LABELS;
                    for (int dr = -1; dr <= 1; dr++) begin
                        for (int dc = -1; dc <= 1; dc++) begin
                            nr = n / DIM + dr;
                            nc = n % DIM + dc;
                            if (nr >= 0 && nr < DIM && nc >= 0 && nc < DIM &&
                                img[nr*DIM+nc] && !seen[nr*DIM+nc]) begin
                                seen[nr*DIM+nc] = 1'b1;
                                q.push_back(nr*DIM + nc);
                            end
                        end
                    end
                end
            end
        end
    endfunction

    // --------------------------------------------------
    // Bus monitor
    // --------------------------------------------------

    always @(posedge clk) begin
        if (reset || reset_prev) begin
            check_eq("sram_wen", sram_wen, 1);
            check_eq("finish", finish, 0);
            check_eq("rom_a", rom_a, 0);
            check_eq("sram_a", sram_a, 0);
            check_eq("sram_d", sram_d, 0);
            wr_count  = 0;
            done_seen = 1'b0;
        end else begin
            if (!sram_wen) begin
                assert (!done_seen) else begin
                    errors++;
                    $display("Error at %0t: SRAM written after finish rose", $time);
                end
                // First 1024 writes are the clear sweep
                if (wr_count < `CCL_PIXELS) begin
                    check_eq("sram_a", sram_a, wr_count);
                    check_eq("sram_d", sram_d, 0);
                end
                check_eq("sram_d[7:5]", sram_d[7:5], 0);
                wr_count++;
            end
            if (done_seen) begin
                check_eq("finish", finish, 1);
            end
            if (finish) begin
                done_seen = 1'b1;
            end
        end
        reset_prev = reset;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: finish did not rise within %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Mode 0 is blank, 1 is full and 2 is random at about 30 percent
    task automatic run_image(input int mode);
        logic [7:0] b;
        for (int p = 0; p < `CCL_PIXELS; p++) begin
            img[p] = (mode == 1) || ((mode == 2) && ($urandom_range(99) < 30));
        end
        for (int a = 0; a < `CCL_ROM_DEPTH; a++) begin
            for (int k = 0; k < 8; k++) begin
                b[7-k] = img[a*8 + k];
            end
            mem.rom[a] = b;
        end
        mem.fill_sram();
        label_image();
        @(posedge clk);
        #2 reset = 1'b1;
        repeat (16) @(posedge clk);
        #2 reset = 1'b0;
        while (!finish) begin
            @(posedge clk);
            #2;
        end
        repeat (20) @(posedge clk);
        assert (wr_count >= `CCL_PIXELS) else begin
            errors++;
            $display("Error at %0t: clear phase wrote only %0d words", $time, wr_count);
        end
        for (int p = 0; p < `CCL_PIXELS; p++) begin
            check_eq($sformatf("sram[%0d]", p), mem.sram[p], exp_label[p]);
        end
    endtask

    initial begin
        reset      = 1'b1;
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        reset_prev = 1'b1;
        void'($urandom(32'hdd9ab20c));
        run_image(0);
        run_image(1);
        repeat (3) run_image(2);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* test/ccl_mem_models.sv */
`timescale 1ns/1ps

`include "ccl_config.svh"

module ccl_mem_models (
    input  logic                              clk,
    input  logic [$clog2(`CCL_ROM_DEPTH)-1:0] rom_a,
    output logic [7:0]                        rom_q,
    input  logic [$clog2(`CCL_PIXELS)-1:0]    sram_a,
    input  logic [7:0]                        sram_d,
    input  logic                              sram_wen
);

    logic [7:0] rom [`CCL_ROM_DEPTH];
    logic [7:0] sram [`CCL_PIXELS];

    initial begin
        rom_q = 8'h00;
    end

    // Synchronous ROM read and active-low SRAM write
    always @(posedge clk) begin
        rom_q <= rom[rom_a];
        if (!sram_wen) begin
            sram[sram_a] <= sram_d;
        end
    end

    // Junk pattern so a missed clear write shows up
    task automatic fill_sram();
        for (int i = 0; i < `CCL_PIXELS; i++) begin
            sram[i] = 8'((i ^ (i >> 8)) + 8'h5a);
        end
    endtask

endmodule

/* logic/ccl_top.sv */
`timescale 1ns/1ps

`include "ccl_config.svh"

module ccl_top (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [7:0]                        rom_q,
    output logic [$clog2(`CCL_ROM_DEPTH)-1:0] rom_a,
    output logic [$clog2(`CCL_PIXELS)-1:0]    sram_a,
    output logic [7:0]                        sram_d,
    output logic                              sram_wen,
    output logic                              finish
);

    import ccl_pkg::*;

    pixel_index_t cur_index;
    pixel_index_t nbr_index;
    pixel_index_t map_index;
    dir_t         dir;
    logic         in_image;
    logic         visited_bit;
    logic         set_en;
    logic         clear_en;
    logic [$clog2(`CCL_ROM_DEPTH)-1:0] clear_addr;

    ccl_sequencer u_sequencer (
        .clk         (clk),
        .reset       (reset),
        .rom_q       (rom_q),
        .rom_a       (rom_a),
        .sram_a      (sram_a),
        .sram_d      (sram_d),
        .sram_wen    (sram_wen),
        .finish      (finish),
        .cur_index   (cur_index),
        .dir         (dir),
        .nbr_index   (nbr_index),
        .in_image    (in_image),
        .map_index   (map_index),
        .visited_bit (visited_bit),
        .set_en      (set_en),
        .clear_en    (clear_en),
        .clear_addr  (clear_addr)
    );

    ccl_neighbor_gen u_neighbor_gen (
        .cur_index (cur_index),
        .dir       (dir),
        .nbr_index (nbr_index),
        .in_image  (in_image)
    );

    // Same index reads the flag and, on a write cycle, sets it
    ccl_visited_map u_visited_map (
        .clk         (clk),
        .reset       (reset),
        .clear_en    (clear_en),
        .clear_addr  (clear_addr),
        .set_en      (set_en),
        .set_index   (map_index),
        .read_index  (map_index),
        .visited_bit (visited_bit)
    );

endmodule

/* logic/ccl_sequencer.sv */
`timescale 1ns/1ps

`include "ccl_config.svh"

module ccl_sequencer (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [7:0]                        rom_q,
    output logic [$clog2(`CCL_ROM_DEPTH)-1:0] rom_a,
    output logic [$clog2(`CCL_PIXELS)-1:0]    sram_a,
    output logic [7:0]                        sram_d,
    output logic                              sram_wen,
    output logic                              finish,
    output ccl_pkg::pixel_index_t             cur_index,
    output ccl_pkg::dir_t                     dir,
    input  ccl_pkg::pixel_index_t             nbr_index,
    input  logic                              in_image,
    output ccl_pkg::pixel_index_t             map_index,
    input  logic                              visited_bit,
    output logic                              set_en,
    output logic                              clear_en,
    output logic [$clog2(`CCL_ROM_DEPTH)-1:0] clear_addr
);

    import ccl_pkg::*;

    localparam int PIX_BITS  = $clog2(`CCL_PIXELS);
    localparam int BYTE_BITS = $clog2(`CCL_ROM_DEPTH);
    localparam logic [PIX_BITS-1:0] LAST_PIXEL = PIX_BITS'(`CCL_PIXELS - 1);

    typedef enum logic [3:0] {
        S_IDLE,
        S_CLEAR,
        S_SEED_ADDR,
        S_SEED_READ,
        S_SEED_WRITE,
        S_GROW_ADDR,
        S_GROW_READ,
        S_NBR_ADDR,
        S_NBR_READ,
        S_NBR_WRITE,
        S_DONE
    } state_t;

    state_t        state;
    state_t        next_state;
    state_t        sweep_next;
    logic [PIX_BITS-1:0] clr_cnt;
    pixel_index_t  seed_idx;
    pixel_index_t  pix_idx;
    pixel_index_t  active_idx;
    label_t        label;
    logic          wrote;
    logic          sweep_dirty;
    logic          pixel_fg;
    logic          dir_last;
    logic          clr_step;
    logic          seed_step;
    logic          label_inc;
    logic          pix_step;
    logic          pix_clear;
    logic          dir_step;

    // --------------------------------------------------
    // Pixel under test
    // --------------------------------------------------

    always_comb begin
        case (state)
            S_SEED_ADDR, S_SEED_READ, S_SEED_WRITE: active_idx = seed_idx;
            S_NBR_ADDR, S_NBR_READ, S_NBR_WRITE:    active_idx = nbr_index;
            default:                                active_idx = pix_idx;
        endcase
    end

    // bit_sel 0 is the ROM's MSB
    assign pixel_fg  = rom_q[3'd7 - active_idx.loc.bit_sel];
    assign map_index = active_idx;
    assign cur_index = pix_idx;
    assign dir_last  = (dir == DIR_RIGHT_DOWN);

    // Count a write issued in the current cycle too
    assign sweep_dirty = wrote || (state == S_NBR_WRITE);
    assign sweep_next  = ((pix_idx == LAST_PIXEL) && !sweep_dirty) ? S_SEED_ADDR : S_GROW_ADDR;

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------

    always_comb begin
        next_state = state;
        clr_step   = 1'b0;
        seed_step  = 1'b0;
        label_inc  = 1'b0;
        pix_step   = 1'b0;
        pix_clear  = 1'b0;
        dir_step   = 1'b0;
        case (state)
            S_IDLE: next_state = S_CLEAR;
            S_CLEAR: begin
                clr_step = 1'b1;
                if (clr_cnt == LAST_PIXEL) begin
                    next_state = S_SEED_ADDR;
                end
            end
            S_SEED_ADDR: next_state = S_SEED_READ;
            S_SEED_READ: begin
                if (pixel_fg && !visited_bit) begin
                    label_inc  = 1'b1;
                    next_state = S_SEED_WRITE;
                end else if (seed_idx == LAST_PIXEL) begin
                    next_state = S_DONE;
                end else begin
                    seed_step  = 1'b1;
                    next_state = S_SEED_ADDR;
                end
            end
            S_SEED_WRITE: begin
                pix_clear  = 1'b1;
                next_state = S_GROW_ADDR;
            end
            S_GROW_ADDR: next_state = S_GROW_READ;
            S_GROW_READ: begin
                if (pixel_fg && visited_bit) begin
                    next_state = S_NBR_ADDR;
                end else begin
                    pix_step   = 1'b1;
                    next_state = sweep_next;
                end
            end
            S_NBR_ADDR: begin
                if (in_image) begin
                    next_state = S_NBR_READ;
                end else begin
                    dir_step   = 1'b1;
                    pix_step   = dir_last;
                    next_state = dir_last ? sweep_next : S_NBR_ADDR;
                end
            end
            S_NBR_READ: begin
                if (pixel_fg && !visited_bit) begin
                    next_state = S_NBR_WRITE;
                end else begin
                    dir_step   = 1'b1;
                    pix_step   = dir_last;
                    next_state = dir_last ? sweep_next : S_NBR_ADDR;
                end
            end
            S_NBR_WRITE: begin
                dir_step   = 1'b1;
                pix_step   = dir_last;
                next_state = dir_last ? sweep_next : S_NBR_ADDR;
            end
            S_DONE: next_state = S_DONE;
            default: next_state = S_IDLE;
        endcase
    end

    // --------------------------------------------------
    // Registers
    // --------------------------------------------------

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= S_IDLE;
            clr_cnt  <= '0;
            seed_idx <= '0;
            pix_idx  <= '0;
            dir      <= DIR_LEFT_UP;
            label    <= '0;
            wrote    <= 1'b0;
        end else begin
            state <= next_state;
            if (clr_step) begin
                clr_cnt <= clr_cnt + 1'b1;
            end
            if (seed_step) begin
                seed_idx <= pixel_index_t'(seed_idx + 1'b1);
            end
            if (label_inc) begin
                label <= label + 1'b1;
            end
            // Wraps back to pixel 0 at the end of a sweep
            if (pix_clear) begin
                pix_idx <= '0;
            end else if (pix_step) begin
                pix_idx <= pixel_index_t'(pix_idx + 1'b1);
            end
            // Wraps to DIR_LEFT_UP after the last direction
            if (dir_step) begin
                dir <= dir_t'(dir + 3'd1);
            end
            if (pix_clear || (pix_step && (pix_idx == LAST_PIXEL))) begin
                wrote <= 1'b0;
            end else if (state == S_NBR_WRITE) begin
                wrote <= 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // Memory strobes
    // --------------------------------------------------

    always_comb begin
        rom_a    = '0;
        sram_a   = '0;
        sram_d   = 8'h00;
        sram_wen = 1'b1;
        set_en   = 1'b0;
        case (state)
            S_CLEAR: begin
                sram_a   = clr_cnt;
                sram_wen = 1'b0;
            end
            S_SEED_ADDR, S_GROW_ADDR, S_NBR_ADDR: begin
                rom_a = active_idx.loc.byte_addr;
            end
            S_SEED_WRITE, S_NBR_WRITE: begin
                sram_a   = active_idx;
                sram_d   = {{(8-`CCL_LABEL_BITS){1'b0}}, label};
                sram_wen = 1'b0;
                set_en   = 1'b1;
            end
            default: begin
                rom_a = '0;
            end
        endcase
    end

    // Visited map only needs the first 128 clear cycles
    assign clear_en   = (state == S_CLEAR) && (clr_cnt < `CCL_ROM_DEPTH);
    assign clear_addr = clr_cnt[BYTE_BITS-1:0];
    assign finish     = (state == S_DONE);

endmodule

/* logic/ccl_neighbor_gen.sv */
`timescale 1ns/1ps

`include "ccl_config.svh"

module ccl_neighbor_gen (
    input  ccl_pkg::pixel_index_t cur_index,
    input  ccl_pkg::dir_t         dir,
    output ccl_pkg::pixel_index_t nbr_index,
    output logic                  in_image
);

    import ccl_pkg::*;

    localparam logic [`CCL_DIM_BITS-1:0] DIM_MAX = '1;

    logic row_dec;
    logic row_inc;
    logic col_dec;
    logic col_inc;

    // Row and column steps per direction
    always_comb begin
        row_dec = 1'b0;
        row_inc = 1'b0;
        col_dec = 1'b0;
        col_inc = 1'b0;
        case (dir)
            DIR_LEFT_UP: begin
                row_dec = 1'b1;
                col_dec = 1'b1;
            end
            DIR_UP:       row_dec = 1'b1;
            DIR_RIGHT_UP: begin
                row_dec = 1'b1;
                col_inc = 1'b1;
            end
            DIR_LEFT:     col_dec = 1'b1;
            DIR_RIGHT:    col_inc = 1'b1;
            DIR_LEFT_DOWN: begin
                row_inc = 1'b1;
                col_dec = 1'b1;
            end
            DIR_DOWN:     row_inc = 1'b1;
            default: begin
                row_inc = 1'b1;
                col_inc = 1'b1;
            end
        endcase
    end

    always_comb begin
        nbr_index.pos.row = cur_index.pos.row + {{(`CCL_DIM_BITS-1){row_dec}}, row_dec | row_inc};
        nbr_index.pos.col = cur_index.pos.col + {{(`CCL_DIM_BITS-1){col_dec}}, col_dec | col_inc};
    end

    // Border test, so the index never wraps into another row
    assign in_image = !((row_dec && (cur_index.pos.row == '0))     ||
                        (row_inc && (cur_index.pos.row == DIM_MAX)) ||
                        (col_dec && (cur_index.pos.col == '0))     ||
                        (col_inc && (cur_index.pos.col == DIM_MAX)));

endmodule

/* logic/ccl_visited_map.sv */
`timescale 1ns/1ps

`include "ccl_config.svh"

module ccl_visited_map (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              clear_en,
    input  logic [$clog2(`CCL_ROM_DEPTH)-1:0] clear_addr,
    input  logic                              set_en,
    input  ccl_pkg::pixel_index_t             set_index,
    input  ccl_pkg::pixel_index_t             read_index,
    output logic                              visited_bit
);

    // One flag per pixel, grouped like the image ROM
    logic [7:0] map [`CCL_ROM_DEPTH];

    // --------------------------------------------------
    // Read path
    // --------------------------------------------------

    assign visited_bit = map[read_index.loc.byte_addr][read_index.loc.bit_sel];

    // --------------------------------------------------
    // Byte clear and bit set
    // --------------------------------------------------

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `CCL_ROM_DEPTH; i++) begin
                map[i] <= 8'h00;
            end
        end else begin
            if (clear_en) begin
                map[clear_addr] <= 8'h00;
            end
            // Set after clear so a same-edge set survives
            if (set_en) begin
                map[set_index.loc.byte_addr][set_index.loc.bit_sel] <= 1'b1;
            end
        end
    end

endmodule

/* logic/ccl_pkg.sv */
`include "ccl_config.svh"

package ccl_pkg;

    // Pixel as row and column
    typedef struct packed {
        logic [`CCL_DIM_BITS-1:0] row;
        logic [`CCL_DIM_BITS-1:0] col;
    } pixel_pos_t;

    // Pixel as ROM byte and bit within the byte
    typedef struct packed {
        logic [$clog2(`CCL_ROM_DEPTH)-1:0] byte_addr;
        logic [2:0]                        bit_sel;
    } pixel_loc_t;

    // Same raster index word, two decodings
    typedef union packed {
        pixel_pos_t pos;
        pixel_loc_t loc;
    } pixel_index_t;

    // Neighbour directions in sweep order
    typedef enum logic [2:0] {
        DIR_LEFT_UP    = 3'd0,
        DIR_UP         = 3'd1,
        DIR_RIGHT_UP   = 3'd2,
        DIR_LEFT       = 3'd3,
        DIR_RIGHT      = 3'd4,
        DIR_LEFT_DOWN  = 3'd5,
        DIR_DOWN       = 3'd6,
        DIR_RIGHT_DOWN = 3'd7
    } dir_t;

    typedef logic [`CCL_LABEL_BITS-1:0] label_t;

endpackage

/* logic/ccl_config.svh */
`ifndef CCL_CONFIG_SVH
`define CCL_CONFIG_SVH

// --------------------------------------------------
// Image geometry
// --------------------------------------------------

// Bits of a row or column index
`define CCL_DIM_BITS 5

// Pixels in the 32 x 32 image
`define CCL_PIXELS 1024

// --------------------------------------------------
// External memories
// --------------------------------------------------

// Image ROM bytes, 8 pixels each
`define CCL_ROM_DEPTH 128

// Width of a component label
`define CCL_LABEL_BITS 5

`endif
